// ==== all.f ====
+incdir+.
isa_pkg.sv
pipe_pkg.sv
dmem_if.sv
pipe_stage.sv
exec_unit.sv
ex_mem_stage.sv
data_mem.sv
load_format.sv
exec_mem_pipe.sv
tb_exec_mem_pipe.sv

// ==== data_mem.sv ====
`timescale 1ns/1ns
`include "pipe_defines.svh"

module data_mem (
    input logic   I_sys_clk,
    input logic   I_rst,
    dmem_if.slave mem
);

    localparam int DEPTH = 1 << `PIPE_DMEM_AW;
    localparam int LANES = `PIPE_XLEN / 8;

    logic [`PIPE_XLEN-1:0]    ram [DEPTH];
    logic [`PIPE_DMEM_AW-1:0] waddr;
    logic [`PIPE_DMEM_AW-1:0] raddr_q;
    logic                     pend;
    logic [1:0]               cnt;

    assign waddr = mem.addr[`PIPE_DMEM_AW+2:3];

    always_ff @(posedge I_sys_clk) begin
        if (I_rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                ram[i] <= '0;
            end
        end else if (mem.wen) begin
            for (int b = 0; b < LANES; b++) begin
                if (mem.wstrb[b]) begin
                    ram[waddr][8*b +: 8] <= mem.wdata[8*b +: 8];
                end
            end
        end
    end

    // latency is 1 + addr[4:3] cycles after rd_en
    always_ff @(posedge I_sys_clk) begin
        if (I_rst) begin
            pend <= 1'b0;
            cnt  <= 2'd0;
        end else if (mem.rd_en) begin
            pend <= 1'b1;
            cnt  <= mem.addr[4:3];
        end else if (pend) begin
            if (cnt == 2'd0) begin
                pend <= 1'b0;
            end else begin
                cnt <= cnt - 2'd1;
            end
        end
    end

    always_ff @(posedge I_sys_clk) begin
        if (mem.rd_en) begin
            raddr_q <= waddr;
        end
    end

    assign mem.rdata_valid = pend && (cnt == 2'd0);
    assign mem.rdata       = ram[raddr_q];

    a_single_read: assert property (
        @(posedge I_sys_clk) disable iff (I_rst)
        mem.rd_en |-> !pend
    );

endmodule

// ==== dmem_if.sv ====
`timescale 1ns/1ns
`include "pipe_defines.svh"

interface dmem_if;
    logic                    rd_en;
    logic                    wen;
    logic [`PIPE_XLEN-1:0]   addr;
    logic [`PIPE_XLEN-1:0]   wdata;
    logic [`PIPE_XLEN/8-1:0] wstrb;
    logic [`PIPE_XLEN-1:0]   rdata;
    logic                    rdata_valid;

    // memory stage side
    modport master (
        output rd_en, wen, addr, wdata, wstrb,
        input  rdata, rdata_valid
    );

    // memory side
    modport slave (
        input  rd_en, wen, addr, wdata, wstrb,
        output rdata, rdata_valid
    );

endinterface

// ==== ex_mem_stage.sv ====
`timescale 1ns/1ns
`include "pipe_defines.svh"

module ex_mem_stage
    import pipe_pkg::*;
(
    input  logic                  I_sys_clk,
    input  logic                  I_rst,
    input  logic                  in_valid,
    output logic                  in_allowin,
    input  ex_mem_t               in_data,
    dmem_if.master                mem,
    output logic                  out_valid,
    input  logic                  out_allowout,
    output ex_mem_t               out_data,
    output logic [`PIPE_XLEN-1:0] out_rdata
);

    logic                  hold_valid;
    ex_mem_t               hold;
    logic                  rd_pulse;
    logic                  done;
    logic [`PIPE_XLEN-1:0] rdata_q;
    logic                  take_in;
    logic                  hand_off;

    // loads wait for the memory, everything else is ready at once
    assign out_valid  = hold_valid && (!hold.mem_rd || done || mem.rdata_valid);
    assign hand_off   = out_valid && out_allowout;
    assign in_allowin = !hold_valid || hand_off;
    assign take_in    = in_valid && in_allowin;

    assign out_data  = hold;
    assign out_rdata = done ? rdata_q : mem.rdata;

    assign mem.rd_en = rd_pulse;
    // store commits only on the handoff edge, so exactly once
    assign mem.wen   = hold.mem_wen && hand_off;
    assign mem.addr  = hold.mem_addr;
    assign mem.wdata = hold.store_data;
    assign mem.wstrb = hold.wstrb;

    always_ff @(posedge I_sys_clk) begin
        if (I_rst) begin
            hold_valid <= 1'b0;
            rd_pulse   <= 1'b0;
        end else begin
            if (in_allowin) begin
                hold_valid <= in_valid;
            end
            rd_pulse <= take_in && in_data.mem_rd;
        end
    end

    always_ff @(posedge I_sys_clk) begin
        if (take_in) begin
            hold <= in_data;
        end
    end

    // returned data is kept while the next stage stalls
    always_ff @(posedge I_sys_clk) begin
        if (I_rst) begin
            done <= 1'b0;
        end else if (hand_off) begin
            done <= 1'b0;
        end else if (mem.rdata_valid) begin
            done <= 1'b1;
        end
    end

    always_ff @(posedge I_sys_clk) begin
        if (mem.rdata_valid) begin
            rdata_q <= mem.rdata;
        end
    end

    // a read goes out for a held load that has not completed yet
    a_rd_only_for_load: assert property (
        @(posedge I_sys_clk) disable iff (I_rst)
        mem.rd_en |-> hold_valid && hold.mem_rd && !out_valid
    );

    a_rdata_needs_read: assert property (
        @(posedge I_sys_clk) disable iff (I_rst)
        mem.rdata_valid |-> hold_valid && hold.mem_rd && !done
    );

endmodule

// ==== exec_mem_pipe.sv ====
`timescale 1ns/1ns
`include "pipe_defines.svh"

module exec_mem_pipe
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic                        I_sys_clk,
    input  logic                        I_rst,
    input  logic                        in_valid,
    input  op_t                         in_op,
    input  mem_size_t                   in_size,
    input  logic [`PIPE_XLEN-1:0]       in_pc,
    input  logic [`PIPE_XLEN-1:0]       in_rs1_data,
    input  logic [`PIPE_XLEN-1:0]       in_rs2_data,
    input  logic [`PIPE_XLEN-1:0]       in_imm,
    input  logic [`PIPE_REG_ADDR_W-1:0] in_rd_addr,
    input  logic                        wb_allowout,
    output logic                        in_allowin,
    output logic                        wb_valid,
    output logic [`PIPE_XLEN-1:0]       wb_pc,
    output logic [`PIPE_REG_ADDR_W-1:0] wb_rd_addr,
    output logic                        wb_reg_wen,
    output logic [`PIPE_XLEN-1:0]       wb_data
);

    id_ex_t                id_in;
    id_ex_t                id_q;
    logic                  id_valid;
    logic                  ex_allowin;
    ex_mem_t               ex_res;
    ex_mem_t               mem_q;
    logic                  mem_valid;
    logic                  wb_allowin;
    logic [`PIPE_XLEN-1:0] mem_rdata;
    mem_wb_t               wb_in;
    mem_wb_t               wb_q;

    dmem_if dbus ();

    assign id_in = '{op: in_op, size: in_size, pc: in_pc, rs1_data: in_rs1_data,
                     rs2_data: in_rs2_data, imm: in_imm, rd_addr: in_rd_addr};

    pipe_stage #(.payload_t(id_ex_t)) u_id_ex (
        .I_sys_clk    (I_sys_clk),
        .I_rst        (I_rst),
        .in_valid     (in_valid),
        .in_allowin   (in_allowin),
        .in_data      (id_in),
        .out_valid    (id_valid),
        .out_allowout (ex_allowin),
        .out_data     (id_q)
    );

    exec_unit u_exec (
        .in  (id_q),
        .out (ex_res)
    );

    ex_mem_stage u_ex_mem (
        .I_sys_clk    (I_sys_clk),
        .I_rst        (I_rst),
        .in_valid     (id_valid),
        .in_allowin   (ex_allowin),
        .in_data      (ex_res),
        .mem          (dbus.master),
        .out_valid    (mem_valid),
        .out_allowout (wb_allowin),
        .out_data     (mem_q),
        .out_rdata    (mem_rdata)
    );

    data_mem u_dmem (
        .I_sys_clk (I_sys_clk),
        .I_rst     (I_rst),
        .mem       (dbus.slave)
    );

    load_format u_ldfmt (
        .in_data (mem_q),
        .rdata   (mem_rdata),
        .out     (wb_in)
    );

    pipe_stage #(.payload_t(mem_wb_t)) u_mem_wb (
        .I_sys_clk    (I_sys_clk),
        .I_rst        (I_rst),
        .in_valid     (mem_valid),
        .in_allowin   (wb_allowin),
        .in_data      (wb_in),
        .out_valid    (wb_valid),
        .out_allowout (wb_allowout),
        .out_data     (wb_q)
    );

    assign wb_pc      = wb_q.pc;
    assign wb_rd_addr = wb_q.rd_addr;
    assign wb_reg_wen = wb_q.reg_wen;
    assign wb_data    = wb_q.wb_data;

endmodule

// ==== exec_unit.sv ====
`timescale 1ns/1ns
`include "pipe_defines.svh"

module exec_unit
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  id_ex_t  in,
    output ex_mem_t out
);

    logic [`PIPE_XLEN-1:0]   addr_sum;
    logic [`PIPE_XLEN-1:0]   addr_al;
    logic [`PIPE_XLEN-1:0]   alu;
    logic [2:0]              off;
    logic [`PIPE_XLEN/8-1:0] base_mask;
    logic [`PIPE_XLEN/8-1:0] mask;
    logic                    is_load;
    logic                    is_store;

    assign is_load  = (in.op == OP_LOAD);
    assign is_store = (in.op == OP_STORE);
    assign addr_sum = in.rs1_data + in.imm;

    // natural alignment, low address bits dropped per access size
    always_comb begin
        case (in.size[1:0])
            2'd0: begin
                addr_al   = addr_sum;
                base_mask = 8'h01;
            end
            2'd1: begin
                addr_al   = {addr_sum[`PIPE_XLEN-1:1], 1'b0};
                base_mask = 8'h03;
            end
            2'd2: begin
                addr_al   = {addr_sum[`PIPE_XLEN-1:2], 2'b00};
                base_mask = 8'h0f;
            end
            default: begin
                addr_al   = {addr_sum[`PIPE_XLEN-1:3], 3'b000};
                base_mask = 8'hff;
            end
        endcase
    end

    assign off  = addr_al[2:0];
    assign mask = base_mask << off;

    always_comb begin
        case (in.op)
            OP_ADD:  alu = in.rs1_data + in.rs2_data;
            OP_SUB:  alu = in.rs1_data - in.rs2_data;
            OP_AND:  alu = in.rs1_data & in.rs2_data;
            OP_OR:   alu = in.rs1_data | in.rs2_data;
            OP_XOR:  alu = in.rs1_data ^ in.rs2_data;
            // memory ops and jal carry the raw target
            default: alu = addr_sum;
        endcase
    end

    always_comb begin
        out.alu_out    = alu;
        out.mem_addr   = addr_al;
        out.store_data = in.rs2_data << {off, 3'b000};
        out.wstrb      = is_store ? mask : '0;
        out.rstrb      = is_load ? {!in.size[2], mask} : '0;
        out.mem_wen    = is_store;
        out.mem_rd     = is_load;
        out.reg_wen    = !is_store;
        out.rd_addr    = in.rd_addr;
        out.pc         = in.pc;
        if (is_load) begin
            out.wb_src = WB_MEM;
        end else if (in.op == OP_JAL) begin
            out.wb_src = WB_PC4;
        end else begin
            out.wb_src = WB_ALU;
        end
    end

endmodule

// ==== isa_pkg.sv ====
package isa_pkg;

    // operations handled by this slice
    typedef enum logic [2:0] {
        OP_ADD   = 3'd0,
        OP_SUB   = 3'd1,
        OP_AND   = 3'd2,
        OP_OR    = 3'd3,
        OP_XOR   = 3'd4,
        OP_LOAD  = 3'd5,
        OP_STORE = 3'd6,
        OP_JAL   = 3'd7
    } op_t;

    // writeback data source
    typedef enum logic [1:0] {
        WB_ALU = 2'd0,
        WB_MEM = 2'd1,
        WB_PC4 = 2'd2
    } wb_src_t;

    // load-style access code, bit 2 set means zero extension
    typedef enum logic [2:0] {
        MEM_B  = 3'd0,
        MEM_H  = 3'd1,
        MEM_W  = 3'd2,
        MEM_D  = 3'd3,
        MEM_BU = 3'd4,
        MEM_HU = 3'd5,
        MEM_WU = 3'd6
    } mem_size_t;

endpackage

// ==== load_format.sv ====
`timescale 1ns/1ns
`include "pipe_defines.svh"

module load_format
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  ex_mem_t               in_data,
    input  logic [`PIPE_XLEN-1:0] rdata,
    output mem_wb_t               out
);

    logic [2:0]              off;
    logic [`PIPE_XLEN/8-1:0] lane;
    logic [`PIPE_XLEN-1:0]   raw;
    logic [`PIPE_XLEN-1:0]   masked;
    logic [`PIPE_XLEN-1:0]   ext;
    logic                    sgn;

    assign off = in_data.mem_addr[2:0];
    assign sgn = in_data.rstrb[`PIPE_XLEN/8];

    always_comb begin
        // move addressed bytes down to lane 0
        raw  = rdata >> {off, 3'b000};
        lane = in_data.rstrb[`PIPE_XLEN/8-1:0] >> off;
        for (int i = 0; i < `PIPE_XLEN/8; i++) begin
            masked[8*i +: 8] = lane[i] ? raw[8*i +: 8] : 8'h00;
        end
        if (lane[7]) begin
            ext = masked;
        end else if (lane[3]) begin
            ext = {{32{sgn & masked[31]}}, masked[31:0]};
        end else if (lane[1]) begin
            ext = {{48{sgn & masked[15]}}, masked[15:0]};
        end else begin
            ext = {{56{sgn & masked[7]}}, masked[7:0]};
        end
    end

    always_comb begin
        out.pc      = in_data.pc;
        out.rd_addr = in_data.rd_addr;
        out.reg_wen = in_data.reg_wen;
        case (in_data.wb_src)
            WB_MEM:  out.wb_data = ext;
            WB_PC4:  out.wb_data = in_data.pc + 64'd4;
            default: out.wb_data = in_data.alu_out;
        endcase
    end

endmodule

// ==== pipe_defines.svh ====
`ifndef PIPE_DEFINES_SVH
`define PIPE_DEFINES_SVH

// datapath width
`define PIPE_XLEN 64

// register file index width
`define PIPE_REG_ADDR_W 5

// doubleword index bits of the data memory, 256 entries
`define PIPE_DMEM_AW 8

`endif

// ==== pipe_pkg.sv ====
`include "pipe_defines.svh"

package pipe_pkg;
    import isa_pkg::*;

    // decoded operation entering execute
    typedef struct packed {
        op_t                         op;
        mem_size_t                   size;
        logic [`PIPE_XLEN-1:0]       pc;
        logic [`PIPE_XLEN-1:0]       rs1_data;
        logic [`PIPE_XLEN-1:0]       rs2_data;
        logic [`PIPE_XLEN-1:0]       imm;
        logic [`PIPE_REG_ADDR_W-1:0] rd_addr;
    } id_ex_t;

    // execute result held in the memory stage
    typedef struct packed {
        logic [`PIPE_XLEN-1:0]       alu_out;
        logic [`PIPE_XLEN-1:0]       mem_addr;
        logic [`PIPE_XLEN-1:0]       store_data;
        logic [`PIPE_XLEN/8-1:0]     wstrb;
        // byte mask plus sign flag in the top bit
        logic [`PIPE_XLEN/8:0]       rstrb;
        logic                        mem_wen;
        logic                        mem_rd;
        wb_src_t                     wb_src;
        logic                        reg_wen;
        logic [`PIPE_REG_ADDR_W-1:0] rd_addr;
        logic [`PIPE_XLEN-1:0]       pc;
    } ex_mem_t;

    // writeback record
    typedef struct packed {
        logic [`PIPE_XLEN-1:0]       pc;
        logic [`PIPE_REG_ADDR_W-1:0] rd_addr;
        logic                        reg_wen;
        logic [`PIPE_XLEN-1:0]       wb_data;
    } mem_wb_t;

endpackage

// ==== pipe_stage.sv ====
`timescale 1ns/1ns

module pipe_stage #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     I_sys_clk,
    input  logic     I_rst,
    input  logic     in_valid,
    output logic     in_allowin,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_allowout,
    output payload_t out_data
);

    logic     valid_q;
    payload_t data_q;

    // free slot, or the held item leaves this cycle
    assign in_allowin = !valid_q || out_allowout;
    assign out_valid  = valid_q;
    assign out_data   = data_q;

    always_ff @(posedge I_sys_clk) begin
        if (I_rst) begin
            valid_q <= 1'b0;
        end else if (in_allowin) begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge I_sys_clk) begin
        if (in_valid && in_allowin) begin
            data_q <= in_data;
        end
    end

    // upstream must keep a refused item steady until it is taken
    a_hold_stable: assert property (
        @(posedge I_sys_clk) disable iff (I_rst)
        in_valid && !in_allowin |=> in_valid && $stable(in_data)
    );

endmodule

// ==== tb_exec_mem_pipe.sv ====
`timescale 1ns/1ns
`include "pipe_defines.svh"

module tb_exec_mem_pipe
    import isa_pkg::*;
();

    localparam int NUM_ITEMS   = 600;
    localparam int FEED_LIMIT  = 20000;
    localparam int DRAIN_LIMIT = 1000;

    // expected writeback record
    typedef struct packed {
        logic [`PIPE_XLEN-1:0]       pc;
        logic [`PIPE_REG_ADDR_W-1:0] rd;
        logic                        reg_wen;
        logic [`PIPE_XLEN-1:0]       data;
        logic                        chk_data;
    } exp_t;

    logic                        I_sys_clk;
    logic                        I_rst;
    logic                        in_valid;
    op_t                         in_op;
    mem_size_t                   in_size;
    logic [`PIPE_XLEN-1:0]       in_pc;
    logic [`PIPE_XLEN-1:0]       in_rs1_data;
    logic [`PIPE_XLEN-1:0]       in_rs2_data;
    logic [`PIPE_XLEN-1:0]       in_imm;
    logic [`PIPE_REG_ADDR_W-1:0] in_rd_addr;
    logic                        wb_allowout;
    logic                        in_allowin;
    logic                        wb_valid;
    logic [`PIPE_XLEN-1:0]       wb_pc;
    logic [`PIPE_REG_ADDR_W-1:0] wb_rd_addr;
    logic                        wb_reg_wen;
    logic [`PIPE_XLEN-1:0]       wb_data;

    logic [63:0] lcg_state;
    logic [63:0] shadow [0:63];
    exp_t        exp_q [$];
    exp_t        held;
    logic        stalled;
    logic        took;
    int          accepted;
    int          cycles;

    exec_mem_pipe uut (
        .I_sys_clk   (I_sys_clk),
        .I_rst       (I_rst),
        .in_valid    (in_valid),
        .in_op       (in_op),
        .in_size     (in_size),
        .in_pc       (in_pc),
        .in_rs1_data (in_rs1_data),
        .in_rs2_data (in_rs2_data),
        .in_imm      (in_imm),
        .in_rd_addr  (in_rd_addr),
        .wb_allowout (wb_allowout),
        .in_allowin  (in_allowin),
        .wb_valid    (wb_valid),
        .wb_pc       (wb_pc),
        .wb_rd_addr  (wb_rd_addr),
        .wb_reg_wen  (wb_reg_wen),
        .wb_data     (wb_data)
    );

    initial begin
        I_sys_clk = 1'b0;
        forever #2 I_sys_clk = ~I_sys_clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 64'd6364136223846793005 + 64'd1442695040888963407;
        return lcg_state[63:32];
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else begin
            abort_run($sformatf("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    // bytes at the aligned address, extended per access code
    function automatic logic [63:0] load_value(input logic [63:0] addr, input logic [2:0] size);
        logic [63:0] bytes;
        bytes = shadow[addr[8:3]] >> {addr[2:0], 3'b000};
        case (size)
            3'd0:    load_value = {{56{bytes[7]}}, bytes[7:0]};
            3'd1:    load_value = {{48{bytes[15]}}, bytes[15:0]};
            3'd2:    load_value = {{32{bytes[31]}}, bytes[31:0]};
            3'd4:    load_value = {56'd0, bytes[7:0]};
            3'd5:    load_value = {48'd0, bytes[15:0]};
            3'd6:    load_value = {32'd0, bytes[31:0]};
            default: load_value = bytes;
        endcase
    endfunction

    task automatic store_bytes(input logic [63:0] addr, input logic [2:0] size,
                               input logic [63:0] data);
        int n;
        int i;
        n = 1 << size[1:0];
        for (i = 0; i < n; i++) begin
            shadow[addr[8:3]][8*(addr[2:0]+i) +: 8] = data[8*i +: 8];
        end
    endtask

    // in-order reference, run when an item is accepted
    task automatic model_accept();
        exp_t        e;
        logic [63:0] addr;
        addr       = (in_rs1_data + in_imm) & ~((64'd1 << in_size[1:0]) - 64'd1);
        e.pc       = in_pc;
        e.rd       = in_rd_addr;
        e.reg_wen  = (in_op != OP_STORE);
        e.chk_data = 1'b1;
        case (in_op)
            OP_ADD:  e.data = in_rs1_data + in_rs2_data;
            OP_SUB:  e.data = in_rs1_data - in_rs2_data;
            OP_AND:  e.data = in_rs1_data & in_rs2_data;
            OP_OR:   e.data = in_rs1_data | in_rs2_data;
            OP_XOR:  e.data = in_rs1_data ^ in_rs2_data;
            OP_LOAD: e.data = load_value(addr, in_size);
            OP_JAL:  e.data = in_pc + 64'd4;
            default: begin
                store_bytes(addr, in_size, in_rs2_data);
                e.data     = '0;
                e.chk_data = 1'b0;
            end
        endcase
        exp_q.push_back(e);
    endtask

    task automatic drive_item();
        logic [31:0] r;
        logic [2:0]  sz;
        r           = lcg_next();
        sz          = r[7:4] % 7;
        in_op       = op_t'(r[2:0]);
        in_size     = mem_size_t'(sz);
        in_rd_addr  = r[12:8];
        in_pc       = {lcg_next(), lcg_next()};
        in_rs2_data = {lcg_next(), lcg_next()};
        // memory ops stay inside a 32 doubleword window
        if (in_op == OP_LOAD || in_op == OP_STORE) begin
            in_rs1_data = {56'd0, r[23:16] & 8'hf8};
            in_imm      = {61'd0, r[26:24]};
        end else begin
            in_rs1_data = {lcg_next(), lcg_next()};
            in_imm      = {lcg_next(), lcg_next()};
        end
    endtask

    task automatic check_writeback();
        exp_t e;
        // a stalled record must stay put
        if (stalled) begin
            check_value("wb_valid", wb_valid, 64'd1);
            check_value("wb_pc", wb_pc, held.pc);
            check_value("wb_rd_addr", wb_rd_addr, held.rd);
            check_value("wb_reg_wen", wb_reg_wen, held.reg_wen);
            check_value("wb_data", wb_data, held.data);
        end
        if (wb_valid && wb_allowout) begin
            if (exp_q.size() == 0) begin
                abort_run("a writeback appeared while no item was outstanding");
            end else begin
                e = exp_q.pop_front();
                check_value("wb_pc", wb_pc, e.pc);
                check_value("wb_rd_addr", wb_rd_addr, e.rd);
                check_value("wb_reg_wen", wb_reg_wen, e.reg_wen);
                if (e.chk_data) begin
                    check_value("wb_data", wb_data, e.data);
                end
            end
        end
        stalled      = wb_valid && !wb_allowout;
        held.pc      = wb_pc;
        held.rd      = wb_rd_addr;
        held.reg_wen = wb_reg_wen;
        held.data    = wb_data;
    endtask

    // drive on the falling edge, sample 1 ns later
    task automatic run_cycle(input logic feed);
        @(negedge I_sys_clk);
        wb_allowout = (lcg_next() % 10) < 7;
        if (!in_valid || took) begin
            in_valid = feed && ((lcg_next() % 10) < 7);
            drive_item();
        end
        #1;
        took = in_valid && in_allowin;
        if (took) begin
            model_accept();
            accepted++;
        end
        check_writeback();
    endtask

    initial begin
        lcg_state   = 64'd85419;
        I_rst       = 1'b1;
        in_valid    = 1'b0;
        in_op       = OP_ADD;
        in_size     = MEM_B;
        in_pc       = '0;
        in_rs1_data = '0;
        in_rs2_data = '0;
        in_imm      = '0;
        in_rd_addr  = '0;
        wb_allowout = 1'b0;
        stalled     = 1'b0;
        took        = 1'b0;
        accepted    = 0;
        held        = '0;
        for (int i = 0; i < 64; i++) begin
            shadow[i] = '0;
        end

        repeat (16) @(posedge I_sys_clk);
        @(negedge I_sys_clk);
        // reset state, output side empty and input side open
        check_value("wb_valid", wb_valid, 64'd0);
        check_value("in_allowin", in_allowin, 64'd1);
        I_rst = 1'b0;
        #1;
        cycles = 0;
        while (!in_allowin) begin
            @(negedge I_sys_clk);
            #1;
            cycles++;
            if (cycles > 20) begin
                abort_run("in_allowin never rose after reset was released");
            end
        end

        cycles = 0;
        while (accepted < NUM_ITEMS) begin
            run_cycle(1'b1);
            cycles++;
            if (cycles > FEED_LIMIT) begin
                abort_run("timed out while feeding items into the pipeline");
            end
        end

        cycles = 0;
        while (exp_q.size() != 0) begin
            run_cycle(1'b0);
            cycles++;
            if (cycles > DRAIN_LIMIT) begin
                abort_run("timed out while waiting for the pipeline to drain");
            end
        end

        // idle cycles catch any extra writeback
        repeat (8) begin
            run_cycle(1'b0);
        end
        check_value("wb_valid", wb_valid, 64'd0);

        $display("*** PASSED ***");
        $finish;
    end

endmodule
